// ==== ti_mem.f ====
+incdir+src
src/ti_mem_pkg.sv
src/reset_release.sv
src/host_bridge.sv
src/region_decode.sv
src/pad_lane.sv
src/ext_wait.sv
src/read_mux.sv
src/ti_mem_top.sv
test/tb_clock.sv
test/tb_ti_mem.sv

// ==== Bender.yml ====
package:
  name: ti_mem

sources:
  - include_dirs:
      - src
    files:
      - src/ti_mem_pkg.sv
      - src/reset_release.sv
      - src/host_bridge.sv
      - src/region_decode.sv
      - src/pad_lane.sv
      - src/ext_wait.sv
      - src/read_mux.sv
      - src/ti_mem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clock.sv
      - test/tb_ti_mem.sv

// ==== test/tb_ti_mem.sv ====
// tb_ti_mem: stimulus, memory-map model and assertion checks for ti_mem_top
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module tb_ti_mem
  import ti_mem_pkg::*;
();

  localparam int         PAD_WORDS = 16;          // pad words exercised
  localparam word_addr_t PAD_BASE  = 23'h004000;  // byte 08000
  localparam word_addr_t EXT_ADDR  = 23'h001000;  // byte 02000, low expansion
  localparam word_addr_t NONE_ADDR = 23'h002000;  // byte 04000, unmapped

  logic       clk;
  logic       rst;
  logic       lock;
  logic       btn_n;
  logic       sys_rst_n;
  logic       host_rd;
  logic       host_wr;
  host_addr_t host_addr;
  byte_t      host_wdata;
  byte_t      host_rdata;
  byte_t      cpu_ctrl;
  boot_req_t  boot;
  logic       rd_ack;
  logic       wr_ack;
  byte_t      boot_rdata;
  cpu_bus_t   cpu;
  word_t      cpu_rdata;
  logic       mem_busy;
  logic       use_busy;
  logic       ext_as;
  logic       ext_wr_n;
  word_addr_t ext_addr;
  logic       ext_done;
  word_t      ext_rdata;

  logic       rd_chk;        // read issued this cycle
  word_t      rd_exp;        // word expected one cycle later
  word_t      pad_model [PAD_WORDS];
  int         errors;
  int         timeouts;
  integer     seed;
  int         n;
  int         d;
  int         idx;

  tb_clock i_tb_clock (
    .o_clk (clk),
    .o_rst (rst)
  );

  ti_mem_top #(
    .P_RESET_DELAY_BITS (4)
  ) i_dut (
    .clk              (clk),
    .i_rst            (rst),
    .i_lock           (lock),
    .i_btn_n          (btn_n),
    .o_sys_rst_n      (sys_rst_n),
    .i_host_rd        (host_rd),
    .i_host_wr        (host_wr),
    .i_host_addr      (host_addr),
    .i_host_wdata     (host_wdata),
    .o_host_rdata     (host_rdata),
    .o_cpu_ctrl       (cpu_ctrl),
    .o_boot           (boot),
    .i_boot_read_ack  (rd_ack),
    .i_boot_write_ack (wr_ack),
    .i_boot_rdata     (boot_rdata),
    .i_cpu            (cpu),
    .o_cpu_rdata      (cpu_rdata),
    .o_mem_busy       (mem_busy),
    .o_use_busy       (use_busy),
    .o_ext_as         (ext_as),
    .o_ext_wr_n       (ext_wr_n),
    .o_ext_addr       (ext_addr),
    .i_ext_done       (ext_done),
    .i_ext_rdata      (ext_rdata)
  );

  // ==============================
  // helpers
  // ==============================

  // memory map from byte ranges
  function automatic logic in_ext(input word_addr_t a);
    logic [23:0] b;
    b = {a, 1'b0};
    return (b < 24'h004000)                          // console rom and 2000..3FFF
        || (b >= 24'h00A000 && b < 24'h020000)       // high expansion, grom 1xxxx
        || (b >= 24'h030000 && b < 24'h040000)
        || (a[22:20] == 3'b001) || (a[22:20] == 3'b010)
        || (a[22:19] == 4'b0001);
  endfunction

  function automatic logic req_level(input logic is_wr);
    return is_wr ? boot.write_rq : boot.read_rq;
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("Error: %0t: %s", $time, msg);
  endtask

  task automatic end_run();
    $display("tb_ti_mem: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
    end_run();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;   // drive point
  endtask

  task automatic bus_idle();
    cpu.oe_n = 1'b1;
    cpu.we_n = 1'b1;
    cpu.lb_n = 1'b1;
    cpu.ub_n = 1'b1;
    cpu.as   = 1'b0;
  endtask

  task automatic wait_release(input string what);
    int k;
    k = 0;
    while (!sys_rst_n && k < 64)
    begin
      next_cycle();
      k++;
    end
    if (!sys_rst_n)
      abort_timeout(what);
  endtask

  task automatic cpu_read(input word_addr_t addr, input word_t exp, input logic strobe);
    cpu.addr = addr;
    cpu.oe_n = 1'b0;
    cpu.we_n = 1'b1;
    cpu.lb_n = 1'b0;
    cpu.ub_n = 1'b0;
    cpu.as   = strobe;
    rd_chk   = 1'b1;
    rd_exp   = exp;
    next_cycle();
  endtask

  task automatic pad_write(input int i, input word_t data, input logic lb_n, input logic ub_n);
    cpu.addr  = PAD_BASE + word_addr_t'(i);
    cpu.oe_n  = 1'b1;
    cpu.we_n  = 1'b0;
    cpu.lb_n  = lb_n;
    cpu.ub_n  = ub_n;
    cpu.as    = 1'b0;
    cpu.wdata = data;
    rd_chk    = 1'b0;
    if (!lb_n)
      pad_model[i][7:0] = data[7:0];     // lane 0
    if (!ub_n)
      pad_model[i][15:8] = data[15:8];   // lane 1
    next_cycle();
  endtask

  task automatic boot_cycle(input logic is_wr);
    int k;
    int dly;
    host_addr = $random(seed);
    host_addr[`TI_HADDR_W-1 -: 4] = `TI_RAM_TAG;
    host_wdata = byte_t'($random(seed));
    host_wr = is_wr;
    host_rd = !is_wr;
    next_cycle();
    host_wr = 1'b0;
    host_rd = 1'b0;
    k = 0;
    while (!req_level(is_wr) && k < 10)
    begin
      next_cycle();
      k++;
    end
    if (!req_level(is_wr))
      abort_timeout("bootloader request to rise");
    dly = 1 + ($random(seed) & 7);   // ack latency, request held at least a cycle
    repeat (dly) next_cycle();
    boot_rdata = byte_t'($random(seed));
    wr_ack = is_wr;
    rd_ack = !is_wr;
    next_cycle();
    wr_ack = 1'b0;
    rd_ack = 1'b0;
    k = 0;
    while (req_level(is_wr) && k < 10)
    begin
      next_cycle();
      k++;
    end
    if (req_level(is_wr))
      abort_timeout("bootloader request to fall");
  endtask

  // ==============================
  // checks
  // ==============================
  a_btn: assert property (@(posedge clk) disable iff (rst) !btn_n |=> !sys_rst_n)
    else log_error("system reset released after button press");
  a_lock: assert property (@(posedge clk) disable iff (rst) !lock |=> !sys_rst_n)
    else log_error("system reset released without lock");

  a_ctrl_wr: assert property (@(posedge clk) disable iff (rst)
    (host_wr && host_addr[`TI_HADDR_W-1 -: 8] == `TI_CTRL_TAG)
      |=> cpu_ctrl == $past(host_wdata))
    else log_error("control register not loaded by host write");
  a_ctrl_rd: assert property (@(posedge clk) disable iff (rst)
    (host_rd && !host_wr && host_addr[`TI_HADDR_W-1 -: 8] == `TI_CTRL_TAG)
      |=> cpu_ctrl == $past(cpu_ctrl))
    else log_error("control register changed by host read");

  a_rd_rise: assert property (@(posedge clk) disable iff (rst)
    (host_rd && host_addr[`TI_HADDR_W-1 -: 4] == `TI_RAM_TAG && !rd_ack)
      |=> (boot.read_rq && boot.addr == $past(host_addr)))
    else log_error("read request or address wrong after host read");
  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    (boot.read_rq && !rd_ack) |=> boot.read_rq)
    else log_error("read request dropped without ack");
  a_rd_ack: assert property (@(posedge clk) disable iff (rst)
    rd_ack |=> (!boot.read_rq && host_rdata == $past(boot_rdata)))
    else log_error("read ack did not clear request or load host data");
  a_wr_rise: assert property (@(posedge clk) disable iff (rst)
    (host_wr && host_addr[`TI_HADDR_W-1 -: 4] == `TI_RAM_TAG && !wr_ack)
      |=> (boot.write_rq && boot.addr == $past(host_addr)
           && boot.wdata == $past(host_wdata)))
    else log_error("write request, address or data wrong after host write");
  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    (boot.write_rq && !wr_ack) |=> boot.write_rq)
    else log_error("write request dropped without ack");
  a_wr_ack: assert property (@(posedge clk) disable iff (rst) wr_ack |=> !boot.write_rq)
    else log_error("write ack did not clear request");

  // read data one cycle after the address
  a_rdata: assert property (@(posedge clk) disable iff (rst)
    rd_chk |=> cpu_rdata == $past(rd_exp))
    else log_error("cpu read data mismatch");

  a_as: assert property (@(posedge clk) disable iff (rst)
    (cpu.as && in_ext(cpu.addr)) |=> ext_as)
    else log_error("external strobe missing after external access");
  a_no_as: assert property (@(posedge clk) disable iff (rst)
    !(cpu.as && in_ext(cpu.addr)) |=> !ext_as)
    else log_error("external strobe without external access");
  a_busy_rise: assert property (@(posedge clk) disable iff (rst)
    (cpu.as && in_ext(cpu.addr) && !ext_done) |=> mem_busy)
    else log_error("memory busy not raised by external strobe");
  a_busy_done: assert property (@(posedge clk) disable iff (rst) ext_done |=> !mem_busy)
    else log_error("memory busy held after done");
  a_busy_idle: assert property (@(posedge clk) disable iff (rst)
    (!mem_busy && !(cpu.as && in_ext(cpu.addr))) |=> !mem_busy)
    else log_error("memory busy raised without external strobe");
  a_use_busy: assert property (@(posedge clk) disable iff (rst)
    use_busy == (in_ext(cpu.addr) && (!cpu.oe_n || !cpu.we_n)))
    else log_error("use_busy does not match external access");
  a_pass: assert property (@(posedge clk) disable iff (rst)
    ext_addr == cpu.addr && ext_wr_n == cpu.we_n)
    else log_error("external address or write enable not passed through");

  // ==============================
  // stimulus
  // ==============================
  initial
  begin
    seed       = 32'h282b;
    errors     = 0;
    timeouts   = 0;
    lock       = 1'b0;
    btn_n      = 1'b1;
    host_rd    = 1'b0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    rd_ack     = 1'b0;
    wr_ack     = 1'b0;
    boot_rdata = '0;
    ext_done   = 1'b0;
    ext_rdata  = '0;
    rd_chk     = 1'b0;
    rd_exp     = '0;
    cpu        = '0;
    bus_idle();

    // reset values, taken while reset is still applied
    @(posedge clk);
    #1;
    a_rst_vals: assert (!ext_as && !mem_busy && !boot.read_rq && !boot.write_rq
                        && !sys_rst_n && cpu_ctrl == '0)
      else log_error("outputs not cleared by reset");

    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (rst && n < 20);
    if (rst)
      abort_timeout("power-on reset to end");
    #1;

    // reset release, button, lock loss
    lock = 1'b1;
    wait_release("system reset release after lock");
    btn_n = 1'b0;
    next_cycle();
    btn_n = 1'b1;
    next_cycle();
    wait_release("system reset release after button");
    lock = 1'b0;
    next_cycle();
    lock = 1'b1;
    next_cycle();
    wait_release("system reset release after lock loss");

    // control register, write then tagged read
    repeat (2)
    begin
      host_wr    = 1'b1;
      host_addr  = {`TI_CTRL_TAG, 24'($random(seed))};
      host_wdata = byte_t'($random(seed));
      next_cycle();
      host_wr    = 1'b0;
      host_rd    = 1'b1;
      host_wdata = byte_t'($random(seed));
      next_cycle();
      host_rd    = 1'b0;
      next_cycle();
    end

    // bootloader read and write requests
    repeat (3)
    begin
      boot_cycle(1'b0);
      boot_cycle(1'b1);
    end

    // scratchpad, full-word fill then mixed byte writes and reads
    for (int i = 0; i < PAD_WORDS; i++)
      pad_write(i, word_t'($random(seed)), 1'b0, 1'b0);
    for (int k = 0; k < 64; k++)
    begin
      idx = $random(seed) & (PAD_WORDS - 1);
      if ($random(seed) & 1)
        pad_write(idx, word_t'($random(seed)), 1'($random(seed)), 1'($random(seed)));
      else
        cpu_read(PAD_BASE + word_addr_t'(idx), pad_model[idx], 1'b0);
    end
    bus_idle();
    rd_chk = 1'b0;
    next_cycle();

    // external read without done, full wait count
    ext_rdata = word_t'($random(seed));
    cpu_read(EXT_ADDR, ext_rdata, 1'b1);
    bus_idle();
    rd_chk = 1'b0;
    n = 0;
    while (mem_busy && n < `TI_WAIT_CYCLES + 10)
    begin
      next_cycle();
      n++;
    end
    if (mem_busy)
      abort_timeout("memory busy to expire");
    a_wait_len: assert (n == `TI_WAIT_CYCLES)
      else log_error("memory busy length differs from wait count");

    // external write ended early by done
    cpu.addr = EXT_ADDR + word_addr_t'($random(seed) & 8'hff);
    cpu.we_n = 1'b0;
    cpu.as   = 1'b1;
    next_cycle();
    bus_idle();
    d = $random(seed) & 7;
    repeat (d) next_cycle();
    ext_done = 1'b1;
    next_cycle();
    ext_done = 1'b0;
    n = 0;
    while (mem_busy && n < 4)
    begin
      next_cycle();
      n++;
    end
    if (mem_busy)
      abort_timeout("memory busy to fall after done");

    // unmapped read, nonzero external data must not leak
    ext_rdata = word_t'($random(seed) | 1);
    cpu_read(NONE_ADDR, '0, 1'b1);
    bus_idle();
    rd_chk = 1'b0;
    repeat (3) next_cycle();   // let pending checks finish
    end_run();
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// tb_clock: free-running testbench clock and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
  parameter real P_PERIOD     = 4.0,   // ns
  parameter int  P_RST_CYCLES = 3
)
(
  output logic o_clk,
  output logic o_rst
);

  initial
  begin
    o_clk = 1'b0;
    forever #(P_PERIOD / 2.0) o_clk = ~o_clk;
  end

  // reset drops 1 ns after the last reset edge
  initial
  begin
    o_rst = 1'b1;
    repeat (P_RST_CYCLES) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== src/ti_mem_top.sv ====
// ti_mem_top: reset release, host bridge, decode, scratchpad lanes, external path
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module ti_mem_top
  import ti_mem_pkg::*;
#(
  parameter int P_RESET_DELAY_BITS = `TI_RESET_DELAY_BITS
)
(
  input  logic       clk,
  input  logic       i_rst,
  // reset sources
  input  logic       i_lock,
  input  logic       i_btn_n,
  output logic       o_sys_rst_n,
  // host port
  input  logic       i_host_rd,
  input  logic       i_host_wr,
  input  host_addr_t i_host_addr,
  input  byte_t      i_host_wdata,
  output byte_t      o_host_rdata,
  output byte_t      o_cpu_ctrl,
  // bootloader side
  output boot_req_t  o_boot,
  input  logic       i_boot_read_ack,
  input  logic       i_boot_write_ack,
  input  byte_t      i_boot_rdata,
  // cpu bus
  input  cpu_bus_t   i_cpu,
  output word_t      o_cpu_rdata,
  output logic       o_mem_busy,
  output logic       o_use_busy,
  // external memory port
  output logic       o_ext_as,
  output logic       o_ext_wr_n,
  output word_addr_t o_ext_addr,
  input  logic       i_ext_done,
  input  word_t      i_ext_rdata
);

  region_t              region;
  logic [`TI_LANES-1:0] lane_we;
  pad_addr_t            pad_addr;
  word_t                lane_rdata;

  // ==============================
  // reset and host
  // ==============================
  reset_release #(
    .P_DELAY_BITS (P_RESET_DELAY_BITS)
  ) i_reset_release (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_lock      (i_lock),
    .i_btn_n     (i_btn_n),
    .o_sys_rst_n (o_sys_rst_n)
  );

  host_bridge i_host_bridge (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_host_rd        (i_host_rd),
    .i_host_wr        (i_host_wr),
    .i_host_addr      (i_host_addr),
    .i_host_wdata     (i_host_wdata),
    .i_boot_read_ack  (i_boot_read_ack),
    .i_boot_write_ack (i_boot_write_ack),
    .i_boot_rdata     (i_boot_rdata),
    .o_cpu_ctrl       (o_cpu_ctrl),
    .o_host_rdata     (o_host_rdata),
    .o_boot           (o_boot)
  );

  // ==============================
  // cpu memory path
  // ==============================
  region_decode i_region_decode (
    .i_cpu      (i_cpu),
    .o_region   (region),
    .o_lane_we  (lane_we),
    .o_pad_addr (pad_addr)
  );

  for (genvar g = 0; g < `TI_LANES; g++)
  begin : g_lane
    pad_lane i_pad_lane (
      .clk     (clk),
      .i_we    (lane_we[g]),
      .i_addr  (pad_addr),
      .i_wdata (i_cpu.wdata[g*8 +: 8]),   // lane g owns byte g
      .o_rdata (lane_rdata[g*8 +: 8])
    );
  end

  ext_wait i_ext_wait (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_cpu      (i_cpu),
    .i_region   (region),
    .i_ext_done (i_ext_done),
    .o_ext_as   (o_ext_as),
    .o_ext_wr_n (o_ext_wr_n),
    .o_ext_addr (o_ext_addr),
    .o_mem_busy (o_mem_busy),
    .o_use_busy (o_use_busy)
  );

  read_mux i_read_mux (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_region     (region),
    .i_lane_rdata (lane_rdata),
    .i_ext_rdata  (i_ext_rdata),
    .o_cpu_rdata  (o_cpu_rdata)
  );

endmodule

`default_nettype wire

// ==== src/read_mux.sv ====
// read_mux: region pipeline stage and cpu read-data select
`timescale 1ns/1ps
`default_nettype none

module read_mux
  import ti_mem_pkg::*;
(
  input  logic    clk,
  input  logic    i_rst,
  input  region_t i_region,
  input  word_t   i_lane_rdata,   // {high lane, low lane}
  input  word_t   i_ext_rdata,
  output word_t   o_cpu_rdata
);

  region_t region_q;   // lines up with ram read latency

  always_ff @(posedge clk)
  begin
    if (i_rst)
      region_q <= REG_NONE;
    else
      region_q <= i_region;
  end

  always_comb
  begin
    case (region_q)
      REG_PAD: o_cpu_rdata = i_lane_rdata;
      REG_EXT: o_cpu_rdata = i_ext_rdata;   // external data not registered
      default: o_cpu_rdata = '0;            // unmapped reads zero
    endcase
  end

endmodule

`default_nettype wire

// ==== src/ext_wait.sv ====
// ext_wait: delayed external strobe, wait-state counter and busy outputs
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module ext_wait
  import ti_mem_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst,
  input  cpu_bus_t   i_cpu,
  input  region_t    i_region,
  input  logic       i_ext_done,    // memory finished the access
  output logic       o_ext_as,
  output logic       o_ext_wr_n,
  output word_addr_t o_ext_addr,
  output logic       o_mem_busy,
  output logic       o_use_busy
);

  localparam int CNT_W = $clog2(`TI_WAIT_CYCLES + 1);

  logic             ext_sel;
  logic             as_ext;     // strobe qualified, combinational
  logic [CNT_W-1:0] busy_cnt;

  assign ext_sel = (i_region == REG_EXT);
  assign as_ext  = i_cpu.as && ext_sel;

  // ==============================
  // strobe delay and wait states
  // ==============================
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      o_ext_as <= 1'b0;
      busy_cnt <= '0;
    end
    else
    begin
      o_ext_as <= as_ext;   // one edge late, memory sees a settled address
      if (i_ext_done)
        busy_cnt <= '0;                       // done cuts the wait short
      else if (as_ext)
        busy_cnt <= CNT_W'(`TI_WAIT_CYCLES);
      else if (busy_cnt != '0)
        busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign o_mem_busy = (busy_cnt != '0);
  assign o_use_busy = ext_sel && (!i_cpu.oe_n || !i_cpu.we_n);

  // straight through to the memory controller
  assign o_ext_wr_n = i_cpu.we_n;
  assign o_ext_addr = i_cpu.addr;

  // memory strobe only ever follows an external cpu strobe
  a_as_follows_cpu: assert property (@(posedge clk) disable iff (i_rst)
    o_ext_as |-> $past(i_cpu.as && (i_region == REG_EXT)));

endmodule

`default_nettype wire

// ==== src/pad_lane.sv ====
// pad_lane: one byte lane of scratchpad ram, synchronous read
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module pad_lane
  import ti_mem_pkg::*;
(
  input  logic      clk,
  input  logic      i_we,
  input  pad_addr_t i_addr,
  input  byte_t     i_wdata,
  output byte_t     o_rdata
);

  localparam int DEPTH = 1 << `TI_PAD_AW;   // 512 bytes

  byte_t mem [DEPTH];

  // single port, read returns the old byte on a write cycle
  always_ff @(posedge clk)
  begin
    if (i_we)
      mem[i_addr] <= i_wdata;
    o_rdata <= mem[i_addr];   // valid one cycle after the address
  end

endmodule

`default_nettype wire

// ==== src/region_decode.sv ====
// region_decode: cpu memory map and scratchpad byte-lane write enables
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module region_decode
  import ti_mem_pkg::*;
(
  input  cpu_bus_t             i_cpu,
  output region_t              o_region,
  output logic [`TI_LANES-1:0] o_lane_we,   // bit 0 low byte
  output pad_addr_t            o_pad_addr
);

  word_addr_t           a;
  logic                 pad_sel;
  logic                 rom_sel;
  logic                 grom_sel;
  logic                 exp_sel;
  logic                 hi_sel;
  logic                 ext_sel;
  logic [`TI_LANES-1:0] be_n;

  assign a = i_cpu.addr;   // word address, byte address is a*2

  // ==============================
  // memory map
  // ==============================
  assign pad_sel  = (a[22:9]  == 14'd32);        // 1K at byte 08000
  assign rom_sel  = (a[22:12] == 11'd0);         // console rom at 0
  assign grom_sel = (a[22:15] == 8'd1)           // grom space 10000..1FFFF
                 || (a[22:15] == 8'd3);          // 30000..3FFFF
  assign exp_sel  = (a[22:12] == 11'd1)          // 2000..3FFF
                 || (a[22:12] == 11'd5)          // A000..BFFF
                 || (a[22:13] == 10'd3);         // C000..FFFF
  assign hi_sel   = (a[22:20] == 3'b001)         // cartridge area
                 || (a[22:20] == 3'b010)
                 || (a[22:19] == 4'b0001);       // paged memory
  assign ext_sel  = rom_sel || grom_sel || exp_sel || hi_sel;

  always_comb
  begin
    if (pad_sel)
      o_region = REG_PAD;
    else if (ext_sel)
      o_region = REG_EXT;
    else
      o_region = REG_NONE;   // e.g. dsr window at 04000
  end

  // per-lane enables, both active low on the bus
  assign be_n      = {i_cpu.ub_n, i_cpu.lb_n};
  assign o_lane_we = (pad_sel && !i_cpu.we_n) ? ~be_n : '0;
  assign o_pad_addr = a[`TI_PAD_AW-1:0];

endmodule

`default_nettype wire

// ==== src/host_bridge.sv ====
// host_bridge: host strobe decode, cpu control register, bootloader request/ack
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module host_bridge
  import ti_mem_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst,
  input  logic       i_host_rd,          // single-cycle strobes
  input  logic       i_host_wr,
  input  host_addr_t i_host_addr,
  input  byte_t      i_host_wdata,
  input  logic       i_boot_read_ack,
  input  logic       i_boot_write_ack,
  input  byte_t      i_boot_rdata,
  output byte_t      o_cpu_ctrl,
  output byte_t      o_host_rdata,
  output boot_req_t  o_boot
);

  logic       ctrl_acc;    // top byte tag
  logic       ram_acc;     // top nibble tag
  host_addr_t boot_addr;
  byte_t      boot_wdata;
  logic       read_rq;
  logic       write_rq;

  assign ctrl_acc = (i_host_addr[`TI_HADDR_W-1 -: 8] == `TI_CTRL_TAG);
  assign ram_acc  = (i_host_addr[`TI_HADDR_W-1 -: 4] == `TI_RAM_TAG);

  // ==============================
  // control register
  // ==============================
  always_ff @(posedge clk)
  begin
    if (i_rst)
      o_cpu_ctrl <= '0;
    else if (i_host_wr && ctrl_acc)
      o_cpu_ctrl <= i_host_wdata;    // reads of the tag do nothing
  end

  // ==============================
  // bootloader requests
  // ==============================

  // address and payload, no reset
  always_ff @(posedge clk)
  begin
    if ((i_host_rd || i_host_wr) && ram_acc)
      boot_addr <= i_host_addr;
    if (!i_boot_write_ack && i_host_wr && ram_acc)
      boot_wdata <= i_host_wdata;    // ack wins, same as the request
    if (i_boot_read_ack)
      o_host_rdata <= i_boot_rdata;  // captured on the ack edge
  end

  // request levels, ack beats a fresh strobe
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      read_rq  <= 1'b0;
      write_rq <= 1'b0;
    end
    else
    begin
      if (i_boot_read_ack)
        read_rq <= 1'b0;
      else if (i_host_rd && ram_acc)
        read_rq <= 1'b1;

      if (i_boot_write_ack)
        write_rq <= 1'b0;
      else if (i_host_wr && ram_acc)
        write_rq <= 1'b1;
    end
  end

  assign o_boot = '{addr: boot_addr, wdata: boot_wdata,
                    read_rq: read_rq, write_rq: write_rq};

  // host must wait for the ack before raising the same request again
  a_rd_no_overlap: assert property (@(posedge clk) disable iff (i_rst)
    (read_rq && !i_boot_read_ack) |-> !(i_host_rd && ram_acc));
  a_wr_no_overlap: assert property (@(posedge clk) disable iff (i_rst)
    (write_rq && !i_boot_write_ack) |-> !(i_host_wr && ram_acc));

endmodule

`default_nettype wire

// ==== src/reset_release.sv ====
// reset_release: lock-qualified delay counter and reset button gating
`timescale 1ns/1ps
`default_nettype none

`include "ti_mem_cfg.svh"

module reset_release
#(
  parameter int P_DELAY_BITS = `TI_RESET_DELAY_BITS
)
(
  input  logic clk,
  input  logic i_rst,
  input  logic i_lock,     // clock source locked
  input  logic i_btn_n,    // reset button, low pressed
  output logic o_sys_rst_n
);

  logic [P_DELAY_BITS-1:0] dly_cnt;
  logic                    dly_done;

  assign dly_done = dly_cnt[P_DELAY_BITS-1];  // half range reached

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      dly_cnt     <= '0;
      o_sys_rst_n <= 1'b0;
    end
    else
    begin
      // lock term here so a lost lock drops reset on the next edge
      o_sys_rst_n <= i_btn_n & i_lock & dly_done;
      if (!i_lock)
        dly_cnt <= '0;                 // restart on every lock loss
      else if (!dly_done)
        dly_cnt <= dly_cnt + 1'b1;     // then sticks at top bit
    end
  end

  // button press must hold the system in reset on the following cycle
  a_btn_holds_reset: assert property (@(posedge clk) disable iff (i_rst)
    !i_btn_n |=> !o_sys_rst_n);

endmodule

`default_nettype wire

// ==== src/ti_mem_pkg.sv ====
// shared typedefs, region enum and bus structs for the memory subsystem
`default_nettype none

`include "ti_mem_cfg.svh"

package ti_mem_pkg;

  // plain vectors with a meaning
  typedef logic [`TI_WADDR_W-1:0]   word_addr_t;  // cpu word address
  typedef logic [`TI_HADDR_W-1:0]   host_addr_t;  // host address
  typedef logic [7:0]               byte_t;
  typedef logic [`TI_LANES*8-1:0]   word_t;       // one byte per lane
  typedef logic [`TI_PAD_AW-1:0]    pad_addr_t;   // scratchpad lane index

  // cpu memory bus, strobes active low except as
  typedef struct packed {
    word_addr_t addr;
    logic       oe_n;   // read
    logic       we_n;   // write
    logic       lb_n;   // low byte enable
    logic       ub_n;   // high byte enable
    logic       as;     // address strobe, one cycle
    word_t      wdata;
  } cpu_bus_t;

  // where a cpu access lands
  typedef enum logic [1:0] {
    REG_NONE = 2'd0,    // unmapped, reads zero
    REG_PAD  = 2'd1,    // on-chip scratchpad
    REG_EXT  = 2'd2     // external memory
  } region_t;

  // bootloader side of the host bridge
  typedef struct packed {
    host_addr_t addr;
    byte_t      wdata;
    logic       read_rq;    // held until read ack
    logic       write_rq;   // held until write ack
  } boot_req_t;

endpackage

`default_nettype wire

// ==== src/ti_mem_cfg.svh ====
// widths, memory map tags, reset delay and wait-state count for the memory subsystem
`ifndef TI_MEM_CFG_SVH
`define TI_MEM_CFG_SVH

// ==============================
// bus widths
// ==============================
`define TI_WADDR_W 23   // cpu word address, A0 is not a byte select
`define TI_HADDR_W 32   // host side address
`define TI_PAD_AW  9    // 512 words per lane
`define TI_LANES   2    // lane 0 low byte, lane 1 high byte

// ==============================
// timing
// ==============================

// reset counter width, top bit releases the system
`define TI_RESET_DELAY_BITS 24

// wait states held on an external access when no done arrives
`define TI_WAIT_CYCLES 100

// ==============================
// host address tags
// ==============================
`define TI_CTRL_TAG 8'hFF   // top byte, cpu control register
`define TI_RAM_TAG  4'h0    // top nibble, bootloader ram window

`endif
